//--- hdl/isaPkg.sv
package isaPkg;

	localparam int instrWidth  = 16;
	localparam int opcodeWidth = 5;

	// field positions inside the instruction word.
	localparam int opcodeMsb = 15;
	localparam int rsLsb     = 8;
	localparam int rtLsb     = 5;
	localparam int rdLsb     = 2;

	// immediate field widths, all starting at bit 0.
	localparam int imm5Width   = 5;  // I1 format.
	localparam int imm8Width   = 8;  // I2 format.
	localparam int disp11Width = 11; // J format.

	localparam logic [opcodeWidth-1:0] OP_HALT  = 5'b0_0000;
	localparam logic [opcodeWidth-1:0] OP_NOP   = 5'b0_0001;
	localparam logic [opcodeWidth-1:0] OP_SIIC  = 5'b0_0010;
	localparam logic [opcodeWidth-1:0] OP_RTI   = 5'b0_0011;
	localparam logic [opcodeWidth-1:0] OP_J     = 5'b0_0100;
	localparam logic [opcodeWidth-1:0] OP_JR    = 5'b0_0101;
	localparam logic [opcodeWidth-1:0] OP_JAL   = 5'b0_0110;
	localparam logic [opcodeWidth-1:0] OP_JALR  = 5'b0_0111;
	localparam logic [opcodeWidth-1:0] OP_ADDI  = 5'b0_1000;
	localparam logic [opcodeWidth-1:0] OP_SUBI  = 5'b0_1001;
	localparam logic [opcodeWidth-1:0] OP_XORI  = 5'b0_1010;
	localparam logic [opcodeWidth-1:0] OP_ANDNI = 5'b0_1011;
	localparam logic [opcodeWidth-1:0] OP_BEQZ  = 5'b0_1100;
	localparam logic [opcodeWidth-1:0] OP_BNEZ  = 5'b0_1101;
	localparam logic [opcodeWidth-1:0] OP_BLTZ  = 5'b0_1110;
	localparam logic [opcodeWidth-1:0] OP_BGEZ  = 5'b0_1111;
	localparam logic [opcodeWidth-1:0] OP_ST    = 5'b1_0000;
	localparam logic [opcodeWidth-1:0] OP_LD    = 5'b1_0001;
	localparam logic [opcodeWidth-1:0] OP_SLBI  = 5'b1_0010;
	localparam logic [opcodeWidth-1:0] OP_STU   = 5'b1_0011;
	localparam logic [opcodeWidth-1:0] OP_ROLI  = 5'b1_0100;
	localparam logic [opcodeWidth-1:0] OP_SLLI  = 5'b1_0101;
	localparam logic [opcodeWidth-1:0] OP_RORI  = 5'b1_0110;
	localparam logic [opcodeWidth-1:0] OP_SRLI  = 5'b1_0111;
	localparam logic [opcodeWidth-1:0] OP_LBI   = 5'b1_1000;
	localparam logic [opcodeWidth-1:0] OP_BTR   = 5'b1_1001;
	localparam logic [opcodeWidth-1:0] OP_SHIFT = 5'b1_1010; // rol, sll, ror, srl.
	localparam logic [opcodeWidth-1:0] OP_ALU   = 5'b1_1011; // add, sub, xor, andn.
	localparam logic [opcodeWidth-1:0] OP_SEQ   = 5'b1_1100;
	localparam logic [opcodeWidth-1:0] OP_SLT   = 5'b1_1101;
	localparam logic [opcodeWidth-1:0] OP_SLE   = 5'b1_1110;
	localparam logic [opcodeWidth-1:0] OP_SCO   = 5'b1_1111;

endpackage

//--- hdl/dpPkg.sv
package dpPkg;

	// default width of the register file and the immediate.
	localparam int defaultDataWidth = 16;

	// register file geometry.
	localparam int regAddrWidth = 3;
	localparam int regCount     = 8;

	// jal and jalr write the return address here.
	localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

endpackage

//--- hdl/control.sv
`timescale 1ns/1ps

module control
(
	input  logic [isaPkg::opcodeWidth-1:0] opcode,
	output logic                           regDst,
	output logic                           aluSrc,
	output logic                           branch,
	output logic                           memRead,
	output logic                           memWrite,
	output logic                           jump,
	output logic                           memToReg,
	output logic                           regWrite,
	output logic                           halt,
	output logic                           zeroExt,
	output logic                           i1Fmt,
	output logic [isaPkg::opcodeWidth-1:0] aluOp
);

	assign aluOp = opcode; // execute decodes the function itself.

	always_comb
	begin
		regDst   = 1'b0; // rd field instead of rt or rs.
		aluSrc   = 1'b0;
		branch   = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		jump     = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		halt     = 1'b0;
		zeroExt  = 1'b0;
		i1Fmt    = 1'b0;
		case (opcode)
			isaPkg::OP_HALT:
			begin
				halt = 1'b1;
			end
			isaPkg::OP_NOP, isaPkg::OP_SIIC, isaPkg::OP_RTI:
			begin
				// nothing reaches the datapath for these
			end
			isaPkg::OP_ADDI, isaPkg::OP_SUBI, isaPkg::OP_ROLI, isaPkg::OP_SLLI,
			isaPkg::OP_RORI, isaPkg::OP_SRLI:
			begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				i1Fmt    = 1'b1;
			end
			isaPkg::OP_XORI, isaPkg::OP_ANDNI:
			begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				i1Fmt    = 1'b1;
				zeroExt  = 1'b1; // logical ops take an unsigned immediate.
			end
			isaPkg::OP_ST:
			begin
				aluSrc   = 1'b1;
				i1Fmt    = 1'b1;
				memWrite = 1'b1;
				memRead  = 1'b1;
				memToReg = 1'b1;
			end
			isaPkg::OP_LD:
			begin
				aluSrc   = 1'b1;
				i1Fmt    = 1'b1;
				memRead  = 1'b1;
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			isaPkg::OP_STU:
			begin
				aluSrc   = 1'b1;
				i1Fmt    = 1'b1;
				memWrite = 1'b1;
				memRead  = 1'b1;
				regWrite = 1'b1; // base register gets the updated address.
			end
			isaPkg::OP_BTR, isaPkg::OP_SHIFT, isaPkg::OP_ALU, isaPkg::OP_SEQ,
			isaPkg::OP_SLT, isaPkg::OP_SLE, isaPkg::OP_SCO:
			begin
				regDst   = 1'b1;
				regWrite = 1'b1;
			end
			isaPkg::OP_BEQZ, isaPkg::OP_BNEZ, isaPkg::OP_BLTZ, isaPkg::OP_BGEZ:
			begin
				aluSrc = 1'b1;
				branch = 1'b1;
			end
			isaPkg::OP_LBI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			isaPkg::OP_SLBI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				zeroExt  = 1'b1; // shifted in below the old low byte.
			end
			isaPkg::OP_J:
			begin
				jump = 1'b1;
			end
			isaPkg::OP_JR:
			begin
				jump   = 1'b1;
				aluSrc = 1'b1; // target is rs plus imm8.
			end
			isaPkg::OP_JAL:
			begin
				jump     = 1'b1;
				regWrite = 1'b1;
			end
			isaPkg::OP_JALR:
			begin
				jump     = 1'b1;
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			default:
			begin
				// every encoding is listed above
			end
		endcase
	end

endmodule

//--- hdl/immGen.sv
`timescale 1ns/1ps

module immGen
#(
	parameter int dataWidth = dpPkg::defaultDataWidth
)
(
	input  logic [isaPkg::instrWidth-1:0] instr,
	input  logic                          i1Fmt,
	input  logic                          zeroExt,
	input  logic                          jump,
	input  logic                          aluSrc,
	output logic [dataWidth-1:0]          imm
);

	localparam int w5  = isaPkg::imm5Width;
	localparam int w8  = isaPkg::imm8Width;
	localparam int w11 = isaPkg::disp11Width;

	logic [w5-1:0]        imm5Field;
	logic [w8-1:0]        imm8Field;
	logic [w11-1:0]       disp11Field;
	logic                 fill5;
	logic                 fill8;
	logic                 fill11;
	logic [dataWidth-1:0] imm5Ext;
	logic [dataWidth-1:0] imm8Ext;
	logic [dataWidth-1:0] disp11Ext;

	assign imm5Field   = instr[w5-1:0];
	assign imm8Field   = instr[w8-1:0];
	assign disp11Field = instr[w11-1:0];

	// fill bit is the field msb unless zero extension is asked for.
	assign fill5  = ~zeroExt & imm5Field[w5-1];
	assign fill8  = ~zeroExt & imm8Field[w8-1];
	assign fill11 = ~zeroExt & disp11Field[w11-1];

	assign imm5Ext   = {{(dataWidth-w5){fill5}}, imm5Field};
	assign imm8Ext   = {{(dataWidth-w8){fill8}}, imm8Field};
	assign disp11Ext = {{(dataWidth-w11){fill11}}, disp11Field};

	always_comb
	begin
		if (i1Fmt)
		begin
			imm = imm5Ext;
		end
		else if (jump && !aluSrc)
		begin
			imm = disp11Ext; // j and jal use the long displacement.
		end
		else
		begin
			imm = imm8Ext; // branches, lbi, slbi, jr, jalr.
		end
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile
#(
	parameter int dataWidth = dpPkg::defaultDataWidth
)
(
	input  logic                          clk,
	input  logic                          rstN,
	input  logic [dpPkg::regAddrWidth-1:0] rsAddr,
	input  logic [dpPkg::regAddrWidth-1:0] rtAddr,
	output logic [dataWidth-1:0]          rsData,
	output logic [dataWidth-1:0]          rtData,
	input  logic                          wrEn,
	input  logic [dpPkg::regAddrWidth-1:0] wrAddr,
	input  logic [dataWidth-1:0]          wrData
);

	logic [dataWidth-1:0] regs [dpPkg::regCount];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < dpPkg::regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// same-cycle writeback is forwarded so decode sees the new value.
	always_comb
	begin
		if (wrEn && (wrAddr == rsAddr))
		begin
			rsData = wrData;
		end
		else
		begin
			rsData = regs[rsAddr];
		end
		if (wrEn && (wrAddr == rtAddr))
		begin
			rtData = wrData;
		end
		else
		begin
			rtData = regs[rtAddr];
		end
	end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
#(
	parameter int dataWidth = dpPkg::defaultDataWidth
)
(
	input  logic                           clk,
	input  logic                           rstN,
	input  logic [isaPkg::instrWidth-1:0]  instr,
	input  logic                           instrValid,
	input  logic                           wbEn,
	input  logic [dpPkg::regAddrWidth-1:0] wbAddr,
	input  logic [dataWidth-1:0]           wbData,
	output logic                           exValid,
	output logic                           regWrite,
	output logic                           memRead,
	output logic                           memWrite,
	output logic                           memToReg,
	output logic                           aluSrc,
	output logic                           branch,
	output logic                           jump,
	output logic                           halt,
	output logic [isaPkg::opcodeWidth-1:0] aluOp,
	output logic [dataWidth-1:0]           rsData,
	output logic [dataWidth-1:0]           rtData,
	output logic [dataWidth-1:0]           imm,
	output logic [dpPkg::regAddrWidth-1:0] writeReg
);

	logic [isaPkg::opcodeWidth-1:0] opcode;
	logic [dpPkg::regAddrWidth-1:0] rsField;
	logic [dpPkg::regAddrWidth-1:0] rtField;
	logic [dpPkg::regAddrWidth-1:0] rdField;

	logic                           decRegDst;
	logic                           decAluSrc;
	logic                           decBranch;
	logic                           decMemRead;
	logic                           decMemWrite;
	logic                           decJump;
	logic                           decMemToReg;
	logic                           decRegWrite;
	logic                           decHalt;
	logic                           decZeroExt;
	logic                           decI1Fmt;
	logic [isaPkg::opcodeWidth-1:0] decAluOp;
	logic [dataWidth-1:0]           decRsData;
	logic [dataWidth-1:0]           decRtData;
	logic [dataWidth-1:0]           decImm;
	logic [dpPkg::regAddrWidth-1:0] decWriteReg;

	assign opcode  = instr[isaPkg::opcodeMsb -: isaPkg::opcodeWidth];
	assign rsField = instr[isaPkg::rsLsb +: dpPkg::regAddrWidth];
	assign rtField = instr[isaPkg::rtLsb +: dpPkg::regAddrWidth];
	assign rdField = instr[isaPkg::rdLsb +: dpPkg::regAddrWidth];

	control controlUnit
	(
		.opcode   (opcode),
		.regDst   (decRegDst),
		.aluSrc   (decAluSrc),
		.branch   (decBranch),
		.memRead  (decMemRead),
		.memWrite (decMemWrite),
		.jump     (decJump),
		.memToReg (decMemToReg),
		.regWrite (decRegWrite),
		.halt     (decHalt),
		.zeroExt  (decZeroExt),
		.i1Fmt    (decI1Fmt),
		.aluOp    (decAluOp)
	);

	immGen #(.dataWidth(dataWidth)) immGenUnit
	(
		.instr   (instr),
		.i1Fmt   (decI1Fmt),
		.zeroExt (decZeroExt),
		.jump    (decJump),
		.aluSrc  (decAluSrc),
		.imm     (decImm)
	);

	regFile #(.dataWidth(dataWidth)) regFileUnit
	(
		.clk    (clk),
		.rstN   (rstN),
		.rsAddr (rsField),
		.rtAddr (rtField),
		.rsData (decRsData),
		.rtData (decRtData),
		.wrEn   (wbEn),
		.wrAddr (wbAddr),
		.wrData (wbData)
	);

	always_comb
	begin
		if (decRegDst)
		begin
			decWriteReg = rdField; // R format.
		end
		else if (decI1Fmt)
		begin
			decWriteReg = rtField;
		end
		else if (decJump)
		begin
			decWriteReg = dpPkg::linkReg;
		end
		else
		begin
			decWriteReg = rsField; // lbi and slbi write rs.
		end
	end

	// control half of the stage register.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			exValid  <= 1'b0;
			regWrite <= 1'b0;
			memRead  <= 1'b0;
			memWrite <= 1'b0;
			memToReg <= 1'b0;
			aluSrc   <= 1'b0;
			branch   <= 1'b0;
			jump     <= 1'b0;
			halt     <= 1'b0;
		end
		else
		begin
			exValid <= instrValid; // one pulse per strobe.
			if (instrValid)
			begin
				regWrite <= decRegWrite;
				memRead  <= decMemRead;
				memWrite <= decMemWrite;
				memToReg <= decMemToReg;
				aluSrc   <= decAluSrc;
				branch   <= decBranch;
				jump     <= decJump;
				halt     <= decHalt;
			end
		end
	end

	// payload half, held between strobes.
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			aluOp    <= decAluOp;
			rsData   <= decRsData;
			rtData   <= decRtData;
			imm      <= decImm;
			writeReg <= decWriteReg;
		end
	end

endmodule

//--- tests/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;

	localparam int dataWidth  = dpPkg::defaultDataWidth;
	localparam int cycleLimit = 20000;

	typedef struct packed
	{
		logic regDst;
		logic aluSrc;
		logic branch;
		logic memRead;
		logic memWrite;
		logic jump;
		logic memToReg;
		logic regWrite;
		logic halt;
		logic zeroExt;
		logic i1Fmt;
	} ctrlT;

	logic                           clk;
	logic                           rstN;
	logic [isaPkg::instrWidth-1:0]  instr;
	logic                           instrValid;
	logic                           wbEn;
	logic [dpPkg::regAddrWidth-1:0] wbAddr;
	logic [dataWidth-1:0]           wbData;
	logic                           exValid;
	logic                           regWrite;
	logic                           memRead;
	logic                           memWrite;
	logic                           memToReg;
	logic                           aluSrc;
	logic                           branch;
	logic                           jump;
	logic                           halt;
	logic [isaPkg::opcodeWidth-1:0] aluOp;
	logic [dataWidth-1:0]           rsData;
	logic [dataWidth-1:0]           rtData;
	logic [dataWidth-1:0]           imm;
	logic [dpPkg::regAddrWidth-1:0] writeReg;

	logic [dataWidth-1:0]           shadow [dpPkg::regCount]; // register file model.
	ctrlT                           expCtrl;
	logic [isaPkg::opcodeWidth-1:0] expAluOp;
	logic [dataWidth-1:0]           expRs;
	logic [dataWidth-1:0]           expRt;
	logic [dataWidth-1:0]           expImm;
	logic [dpPkg::regAddrWidth-1:0] expWr;
	logic                           pendValid = 1'b0; // strobe captured at the next edge.
	logic                           haveLast  = 1'b0;
	int                             strobes   = 0;
	int                             pulses    = 0;
	int                             cycleCount = 0;

	decodeStage #(.dataWidth(dataWidth)) UUT
	(
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.wbEn       (wbEn),
		.wbAddr     (wbAddr),
		.wbData     (wbData),
		.exValid    (exValid),
		.regWrite   (regWrite),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.memToReg   (memToReg),
		.aluSrc     (aluSrc),
		.branch     (branch),
		.jump       (jump),
		.halt       (halt),
		.aluOp      (aluOp),
		.rsData     (rsData),
		.rtData     (rtData),
		.imm        (imm),
		.writeReg   (writeReg)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("run exceeded %0d cycles without finishing", cycleLimit);
			stopOnError();
		end
	end

	task stopOnError();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic expectEqual(input string name, input logic [15:0] got,
		input logic [15:0] want);
		assert (got === want)
		else
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
			stopOnError();
		end
	endtask

	// control set by instruction class.
	function automatic ctrlT expectedControl(input logic [4:0] op);
		ctrlT c;
		c = '0;
		case (op)
			isaPkg::OP_HALT:
				c.halt = 1'b1;
			isaPkg::OP_ADDI, isaPkg::OP_SUBI, isaPkg::OP_XORI, isaPkg::OP_ANDNI,
			isaPkg::OP_ROLI, isaPkg::OP_SLLI, isaPkg::OP_RORI, isaPkg::OP_SRLI:
			begin
				c.aluSrc   = 1'b1;
				c.regWrite = 1'b1;
				c.i1Fmt    = 1'b1;
				c.zeroExt  = (op == isaPkg::OP_XORI) || (op == isaPkg::OP_ANDNI);
			end
			isaPkg::OP_ST, isaPkg::OP_LD, isaPkg::OP_STU:
			begin
				c.aluSrc   = 1'b1;
				c.i1Fmt    = 1'b1;
				c.memRead  = 1'b1;
				c.memWrite = (op != isaPkg::OP_LD);
				c.memToReg = (op != isaPkg::OP_STU);
				c.regWrite = (op != isaPkg::OP_ST);
			end
			isaPkg::OP_BTR, isaPkg::OP_SHIFT, isaPkg::OP_ALU, isaPkg::OP_SEQ,
			isaPkg::OP_SLT, isaPkg::OP_SLE, isaPkg::OP_SCO:
			begin
				c.regDst   = 1'b1;
				c.regWrite = 1'b1;
			end
			isaPkg::OP_BEQZ, isaPkg::OP_BNEZ, isaPkg::OP_BLTZ, isaPkg::OP_BGEZ:
			begin
				c.aluSrc = 1'b1;
				c.branch = 1'b1;
			end
			isaPkg::OP_LBI, isaPkg::OP_SLBI:
			begin
				c.regWrite = 1'b1;
				c.aluSrc   = 1'b1;
				c.zeroExt  = (op == isaPkg::OP_SLBI);
			end
			isaPkg::OP_J, isaPkg::OP_JR, isaPkg::OP_JAL, isaPkg::OP_JALR:
			begin
				c.jump     = 1'b1;
				c.aluSrc   = (op == isaPkg::OP_JR) || (op == isaPkg::OP_JALR);
				c.regWrite = (op == isaPkg::OP_JAL) || (op == isaPkg::OP_JALR);
			end
			default:
				c = '0; // nop, siic and rti.
		endcase
		return c;
	endfunction

	function automatic logic [dataWidth-1:0] expectedImm(input logic [15:0] ins, input ctrlT c);
		int w;
		logic fill;
		logic [dataWidth-1:0] r;
		if (c.i1Fmt)
			w = isaPkg::imm5Width;
		else if (c.jump && !c.aluSrc)
			w = isaPkg::disp11Width;
		else
			w = isaPkg::imm8Width;
		fill = c.zeroExt ? 1'b0 : ins[w-1];
		for (int i = 0; i < dataWidth; i++)
			r[i] = (i < w) ? ins[i] : fill;
		return r;
	endfunction

	task automatic predictOutputs(input logic [15:0] ins, input logic we,
		input logic [2:0] wa, input logic [15:0] wd);
		logic [2:0] rs;
		logic [2:0] rt;
		rs       = ins[isaPkg::rsLsb +: dpPkg::regAddrWidth];
		rt       = ins[isaPkg::rtLsb +: dpPkg::regAddrWidth];
		expAluOp = ins[isaPkg::opcodeMsb -: isaPkg::opcodeWidth];
		expCtrl  = expectedControl(expAluOp);
		expRs    = (we && wa == rs) ? wd : shadow[rs]; // writeback bypass.
		expRt    = (we && wa == rt) ? wd : shadow[rt];
		expImm   = expectedImm(ins, expCtrl);
		if (expCtrl.regDst)
			expWr = ins[isaPkg::rdLsb +: dpPkg::regAddrWidth];
		else if (expCtrl.i1Fmt)
			expWr = rt;
		else if (expCtrl.jump)
			expWr = dpPkg::linkReg;
		else
			expWr = rs;
		haveLast = 1'b1;
	endtask

	// outputs must equal the last prediction, fresh or held.
	task automatic compareOutputs();
		expectEqual("exValid", 16'(exValid), 16'(pendValid));
		if (exValid)
			pulses++;
		if (haveLast)
		begin
			expectEqual("regWrite", 16'(regWrite), 16'(expCtrl.regWrite));
			expectEqual("memRead", 16'(memRead), 16'(expCtrl.memRead));
			expectEqual("memWrite", 16'(memWrite), 16'(expCtrl.memWrite));
			expectEqual("memToReg", 16'(memToReg), 16'(expCtrl.memToReg));
			expectEqual("aluSrc", 16'(aluSrc), 16'(expCtrl.aluSrc));
			expectEqual("branch", 16'(branch), 16'(expCtrl.branch));
			expectEqual("jump", 16'(jump), 16'(expCtrl.jump));
			expectEqual("halt", 16'(halt), 16'(expCtrl.halt));
			expectEqual("aluOp", 16'(aluOp), 16'(expAluOp));
			expectEqual("rsData", rsData, expRs);
			expectEqual("rtData", rtData, expRt);
			expectEqual("imm", imm, expImm);
			expectEqual("writeReg", 16'(writeReg), 16'(expWr));
		end
	endtask

	// one clock of stimulus, checked half a cycle later.
	task automatic driveCycle(input logic v, input logic [15:0] ins, input logic we,
		input logic [2:0] wa, input logic [15:0] wd);
		@(posedge clk);
		instrValid <= v;
		instr      <= ins;
		wbEn       <= we;
		wbAddr     <= wa;
		wbData     <= wd;
		@(negedge clk);
		compareOutputs();
		pendValid = v;
		if (v)
		begin
			predictOutputs(ins, we, wa, wd);
			strobes++;
		end
		if (we)
			shadow[wa] = wd;
	endtask

	task automatic checkControlZero();
		expectEqual("exValid", 16'(exValid), 16'd0);
		expectEqual("control bits", 16'({regWrite, memRead, memWrite, memToReg,
			aluSrc, branch, jump, halt}), 16'd0);
	endtask

	task automatic resetTest();
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			if (i == 9)
				rstN <= 1'b1; // ten edges seen low.
			@(negedge clk);
			checkControlZero();
		end
		for (int i = 0; i < dpPkg::regCount; i++)
			shadow[i] = '0;
		driveCycle(1'b0, 16'd0, 1'b0, 3'd0, 16'd0);
		checkControlZero();
		for (int i = 0; i < dpPkg::regCount; i++)
			driveCycle(1'b1, {isaPkg::OP_NOP, 3'(i), 3'(7 - i), 5'd0}, 1'b0, 3'd0, 16'd0);
	endtask

	task automatic opcodeTest();
		for (int op = 0; op < 32; op++)
			driveCycle(1'b1, {5'(op), 11'($urandom)}, 1'b0, 3'd0, 16'd0);
	endtask

	task automatic registerTest();
		for (int i = 0; i < dpPkg::regCount; i++)
			driveCycle(1'b0, 16'd0, 1'b1, 3'(i), 16'(16'hA5A0 ^ (i * 16'h1111)));
		for (int i = 0; i < dpPkg::regCount; i++)
			driveCycle(1'b1, {isaPkg::OP_ALU, 3'(i), 3'(7 - i), 5'd4}, 1'b0, 3'd0, 16'd0);
		driveCycle(1'b1, {isaPkg::OP_ADDI, 3'd3, 3'd3, 5'd1}, 1'b1, 3'd3, 16'hBEEF);
		driveCycle(1'b1, {isaPkg::OP_ALU, 3'd2, 3'd5, 5'd0}, 1'b1, 3'd5, 16'h1234);
		driveCycle(1'b1, {isaPkg::OP_ALU, 3'd3, 3'd5, 5'd0}, 1'b0, 3'd0, 16'd0);
	endtask

	task automatic immediateTest();
		logic [4:0]  ops [7]  = '{isaPkg::OP_ADDI, isaPkg::OP_XORI, isaPkg::OP_BEQZ,
			isaPkg::OP_SLBI, isaPkg::OP_J, isaPkg::OP_JR, isaPkg::OP_LBI};
		logic [10:0] lows [5] = '{11'h005, 11'h7FF, 11'h3EA, 11'h4D5, 11'h410};
		for (int o = 0; o < 7; o++)
			for (int l = 0; l < 5; l++)
				driveCycle(1'b1, {ops[o], lows[l]}, 1'b0, 3'd0, 16'd0);
	endtask

	task automatic writeRegTest();
		logic [4:0] ops [6] = '{isaPkg::OP_ALU, isaPkg::OP_ADDI, isaPkg::OP_JAL,
			isaPkg::OP_JALR, isaPkg::OP_LBI, isaPkg::OP_SLBI};
		for (int o = 0; o < 6; o++)
			for (int k = 0; k < 3; k++)
				driveCycle(1'b1, {ops[o], 11'($urandom)}, 1'b0, 3'd0, 16'd0);
	endtask

	task automatic randomStreamTest();
		int gapLen;
		for (int n = 0; n < 300; n++)
		begin
			driveCycle(1'b1, 16'($urandom), 1'($urandom), 3'($urandom), 16'($urandom));
			if (2'($urandom) == 2'd0)
			begin
				gapLen = 1 + int'(2'($urandom));
				repeat (gapLen)
					driveCycle(1'b0, 16'($urandom), 1'($urandom), 3'($urandom), 16'($urandom));
			end
		end
		driveCycle(1'b0, 16'd0, 1'b0, 3'd0, 16'd0); // last strobe drains.
	endtask

	initial
	begin
		void'($urandom(73));
		rstN       <= 1'b0;
		instr      <= '0;
		instrValid <= 1'b0;
		wbEn       <= 1'b0;
		wbAddr     <= '0;
		wbData     <= '0;
		resetTest();
		opcodeTest();
		registerTest();
		immediateTest();
		writeRegTest();
		randomStreamTest();
		expectEqual("exValid pulse count", 16'(pulses), 16'(strobes));
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- vlog.f
hdl/isaPkg.sv
hdl/dpPkg.sv
hdl/control.sv
hdl/immGen.sv
hdl/regFile.sv
hdl/decodeStage.sv
tests/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module decodeStageTb -o decodeStageSim

# the log decides the result, so a fatal exit of the simulator is not fatal here
./obj_dir/decodeStageSim | tee sim.log

if grep -q "NO ERRORS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
